// File: files.f
+incdir+hw
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/controlUnit.sv
hw/aluUnit.sv
hw/registerFile.sv
hw/pcUnit.sv
hw/busInterface.sv
hw/mipsCore.sv
verification/mipsCore_props.sv
verification/tbMips.sv

// File: hw/aluUnit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module aluUnit (
	input logic clock,
	input logic reset,
	input logic [`WORD_WIDTH-1:0] a,
	input logic [`WORD_WIDTH-1:0] b,
	input ctrlPkg::aluOpT aluOp,
	input logic aluOutLoad,
	output logic [`WORD_WIDTH-1:0] result,
	output logic [`WORD_WIDTH-1:0] aluOut,
	output logic zero,
	output logic overflow
);
	import ctrlPkg::*;

	localparam int Msb = `WORD_WIDTH - 1;
	localparam int Half = `WORD_WIDTH / 2;

	logic [`WORD_WIDTH-1:0] sum;
	logic [`WORD_WIDTH-1:0] diff;

	assign sum = a + b;
	assign diff = a - b;
	assign zero = (result == '0);

	always_comb begin
		case (aluOp)
			aluSub: result = diff;
			aluAnd: result = a & b;
			aluXor: result = a ^ b;
			aluLui: result = {b[Half-1:0], {Half{1'b0}}};
			default: result = sum;
		endcase
	end

	// Signed overflow only
	always_comb begin
		case (aluOp)
			aluAdd: overflow = (a[Msb] == b[Msb]) && (sum[Msb] != a[Msb]);
			aluSub: overflow = (a[Msb] != b[Msb]) && (diff[Msb] != a[Msb]);
			default: overflow = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			aluOut <= '0;
		else if (aluOutLoad)
			aluOut <= result;
	end

endmodule

// File: hw/busInterface.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module busInterface (
	input logic clock,
	input logic reset,
	input logic busReq,
	input logic busWrite,
	input ctrlPkg::accessSizeT accessSize,
	input logic useAluOutAddr,
	input logic [`WORD_WIDTH-1:0] pc,
	input logic [`WORD_WIDTH-1:0] aluOut,
	input logic [`WORD_WIDTH-1:0] storeData,
	input logic irLoad,
	input logic mdrLoad,
	input logic [`WORD_WIDTH-1:0] wbDatR,
	input logic wbAck,
	output logic busDone,
	output isaPkg::instrWord instr,
	output logic [`WORD_WIDTH-1:0] loadData,
	output logic [`WORD_WIDTH-1:0] wbAdr,
	output logic [`WORD_WIDTH-1:0] wbDatW,
	output logic [3:0] wbSel,
	output logic wbWe,
	output logic wbCyc,
	output logic wbStb
);
	import ctrlPkg::*;

	logic [7:0] laneByte;
	logic isByte;

	assign isByte = (accessSize == accByte);
	assign wbAdr = useAluOutAddr ? aluOut : pc;
	assign wbCyc = busReq;
	assign wbStb = busReq;
	assign wbWe = busReq && busWrite;
	assign wbSel = isByte ? 4'b0001 << wbAdr[1:0] : 4'b1111; // Little-endian lanes
	assign wbDatW = isByte ? {4{storeData[7:0]}} : storeData;
	assign busDone = wbAck;

	assign laneByte = wbDatR[{wbAdr[1:0], 3'b000} +: 8];

	always_ff @(posedge clock) begin
		if (reset)
			instr <= '0;
		else if (irLoad && wbAck)
			instr <= wbDatR;
	end

	always_ff @(posedge clock) begin
		if (mdrLoad && wbAck)
			loadData <= isByte ? {{(`WORD_WIDTH-8){1'b0}}, laneByte} : wbDatR;
	end

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input logic clock,
	input logic reset,
	input isaPkg::instrWord instr,
	input logic busDone,
	input logic zero,
	input logic overflow,
	output logic busReq,
	output logic busWrite,
	output ctrlPkg::accessSizeT accessSize,
	output logic useAluOutAddr,
	output logic irLoad,
	output logic mdrLoad,
	output logic regWrite,
	output logic regDstRd,
	output ctrlPkg::wbSrcT wbSrc,
	output logic abLoad,
	output ctrlPkg::aluOpT aluOp,
	output ctrlPkg::srcASelT srcASel,
	output ctrlPkg::srcBSelT srcBSel,
	output logic aluOutLoad,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic branchOnEqual,
	output ctrlPkg::pcSrcT pcSrc,
	output logic epcWrite,
	output logic halted
);
	import isaPkg::*;
	import ctrlPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;
	opcodeT opcode;
	functT funct;
	accessSizeT memSize;

	assign opcode = instr.r.opcode;
	assign funct = instr.r.funct;
	assign memSize = (opcode == opLbu || opcode == opSb) ? accByte : accWord;
	assign halted = (state == stHalt);

	always_ff @(posedge clock) begin
		if (reset)
			state <= stReset;
		else
			state <= nextState;
	end

	always_comb begin
		busReq = 1'b0;
		busWrite = 1'b0;
		accessSize = accWord;
		useAluOutAddr = 1'b0;
		irLoad = 1'b0;
		mdrLoad = 1'b0;
		regWrite = 1'b0;
		regDstRd = 1'b0;
		wbSrc = wbAluOut;
		abLoad = 1'b0;
		aluOp = aluAdd;
		srcASel = srcAPc;
		srcBSel = srcBStep;
		aluOutLoad = 1'b0;
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		branchOnEqual = 1'b0;
		pcSrc = pcAluResult;
		epcWrite = 1'b0;
		nextState = state;
		case (state)
			stReset: nextState = stFetch;
			stFetch: begin
				busReq = 1'b1;
				irLoad = 1'b1;
				pcWrite = busDone; // pc + 4 when the word arrives
				if (busDone)
					nextState = stDecode;
			end
			stDecode: begin
				abLoad = 1'b1;
				srcBSel = srcBBranch; // Branch target computed early
				aluOutLoad = 1'b1;
				case (opcode)
					opSpecial: begin
						case (funct)
							fnAdd, fnSub, fnAnd, fnXor: nextState = stRExec;
							fnBreak: nextState = stHalt;
							default: nextState = stFetch;
						endcase
					end
					opLw, opLbu, opSw, opSb: nextState = stMemAddr;
					opBeq, opBne: nextState = stBranch;
					opJ: nextState = stJump;
					opLui: nextState = stLui;
					default: nextState = stFetch; // Unknown opcode acts as nop
				endcase
			end
			stMemAddr: begin
				srcASel = srcARegA;
				srcBSel = srcBImm;
				aluOutLoad = 1'b1;
				if (opcode == opLw || opcode == opLbu)
					nextState = stMemRead;
				else
					nextState = stMemWrite;
			end
			stMemRead: begin
				busReq = 1'b1;
				useAluOutAddr = 1'b1;
				accessSize = memSize;
				mdrLoad = 1'b1;
				if (busDone)
					nextState = stLoadWriteBack;
			end
			stLoadWriteBack: begin
				regWrite = 1'b1;
				wbSrc = wbLoadData;
				nextState = stFetch;
			end
			stMemWrite: begin
				busReq = 1'b1;
				busWrite = 1'b1;
				useAluOutAddr = 1'b1;
				accessSize = memSize;
				if (busDone)
					nextState = stFetch;
			end
			stRExec: begin
				srcASel = srcARegA;
				srcBSel = srcBRegB;
				aluOutLoad = 1'b1;
				case (funct)
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnXor: aluOp = aluXor;
					default: aluOp = aluAdd;
				endcase
				nextState = overflow ? stOverflow : stRWriteBack;
			end
			stRWriteBack: begin
				regWrite = 1'b1;
				regDstRd = (opcode == opSpecial); // lui also ends here, writes rt
				nextState = stFetch;
			end
			stOverflow: begin
				epcWrite = 1'b1;
				pcWrite = 1'b1;
				pcSrc = pcExcVector;
				nextState = stFetch;
			end
			stBranch: begin
				srcASel = srcARegA;
				srcBSel = srcBRegB;
				aluOp = aluSub;
				pcWriteCond = 1'b1;
				branchOnEqual = (opcode == opBeq);
				pcSrc = pcAluOut;
				nextState = stFetch;
			end
			stJump: begin
				pcWrite = 1'b1;
				pcSrc = pcJumpTarget;
				nextState = stFetch;
			end
			stLui: begin
				srcBSel = srcBImm;
				aluOp = aluLui;
				aluOutLoad = 1'b1;
				nextState = stRWriteBack;
			end
			stHalt: nextState = stHalt;
			default: nextState = stFetch;
		endcase
	end

endmodule

// File: hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define WORD_WIDTH 32
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

`define RESET_PC 32'h0
`define EXC_VECTOR 32'h80 // Overflow handler entry
`define PC_STEP 32'd4

`endif

// File: hw/ctrlPkg.sv
package ctrlPkg;

	typedef enum logic [3:0] {
		stReset,
		stFetch,
		stDecode,
		stMemAddr,
		stMemRead,
		stLoadWriteBack,
		stMemWrite,
		stRExec,
		stRWriteBack,
		stOverflow,
		stBranch,
		stJump,
		stLui,
		stHalt
	} ctrlStateT;

	typedef enum logic [2:0] {
		aluAdd = 3'b001,
		aluSub = 3'b010,
		aluAnd = 3'b011,
		aluXor = 3'b110,
		aluLui = 3'b111
	} aluOpT;

	typedef enum logic {srcAPc, srcARegA} srcASelT;

	typedef enum logic [1:0] {srcBRegB, srcBStep, srcBImm, srcBBranch} srcBSelT;

	typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJumpTarget, pcExcVector} pcSrcT;

	typedef enum logic {wbAluOut, wbLoadData} wbSrcT;

	typedef enum logic {accWord, accByte} accessSizeT;

endpackage

// File: hw/isaPkg.sv
`include "cpu_macros.svh"

package isaPkg;

	typedef enum logic [5:0] {
		opSpecial = 6'b000000,
		opJ = 6'b000010,
		opBeq = 6'b000100,
		opBne = 6'b000101,
		opLui = 6'b001111,
		opLw = 6'b100011,
		opLbu = 6'b100100,
		opSb = 6'b101000,
		opSw = 6'b101011
	} opcodeT;

	typedef enum logic [5:0] {
		fnBreak = 6'b001101,
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnAnd = 6'b100100,
		fnXor = 6'b100110
	} functT;

	typedef struct packed {
		opcodeT opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [4:0] shamt;
		functT funct;
	} rFormatT;

	typedef struct packed {
		opcodeT opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [15:0] imm;
	} iFormatT;

	// Same word, register view and immediate view
	typedef union packed {
		rFormatT r;
		iFormatT i;
	} instrWord;

endpackage

// File: hw/mipsCore.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mipsCore (
	input logic clock,
	input logic reset,
	input logic [`WORD_WIDTH-1:0] wbDatR,
	input logic wbAck,
	output logic [`WORD_WIDTH-1:0] wbAdr,
	output logic [`WORD_WIDTH-1:0] wbDatW,
	output logic [3:0] wbSel,
	output logic wbWe,
	output logic wbCyc,
	output logic wbStb,
	output logic halted
);
	import isaPkg::*;
	import ctrlPkg::*;

	instrWord instr;
	logic busReq;
	logic busWrite;
	logic busDone;
	accessSizeT accessSize;
	logic useAluOutAddr;
	logic irLoad;
	logic mdrLoad;
	logic regWrite;
	logic regDstRd;
	wbSrcT wbSrc;
	logic abLoad;
	aluOpT aluOp;
	srcASelT srcASel;
	srcBSelT srcBSel;
	logic aluOutLoad;
	logic pcWrite;
	logic pcWriteCond;
	logic branchOnEqual;
	pcSrcT pcSrc;
	logic epcWrite;
	logic zero;
	logic overflow;
	logic [`WORD_WIDTH-1:0] pc;
	logic [`WORD_WIDTH-1:0] aluA;
	logic [`WORD_WIDTH-1:0] aluB;
	logic [`WORD_WIDTH-1:0] aluResult;
	logic [`WORD_WIDTH-1:0] aluOut;
	logic [`WORD_WIDTH-1:0] regA;
	logic [`WORD_WIDTH-1:0] regB;
	logic [`WORD_WIDTH-1:0] readDataA;
	logic [`WORD_WIDTH-1:0] readDataB;
	logic [`WORD_WIDTH-1:0] loadData;
	logic [`WORD_WIDTH-1:0] signExtImm;
	logic [`REG_ADDR_WIDTH-1:0] writeAddr;
	logic [`WORD_WIDTH-1:0] writeData;

	assign signExtImm = {{(`WORD_WIDTH-16){instr.i.imm[15]}}, instr.i.imm};
	assign aluA = (srcASel == srcARegA) ? regA : pc;
	assign writeAddr = regDstRd ? instr.r.rd : instr.i.rt;
	assign writeData = (wbSrc == wbLoadData) ? loadData : aluOut;

	always_comb begin
		case (srcBSel)
			srcBRegB: aluB = regB;
			srcBStep: aluB = `PC_STEP;
			srcBImm: aluB = signExtImm;
			default: aluB = signExtImm << 2; // Word offset to bytes
		endcase
	end

	always_ff @(posedge clock) begin
		if (abLoad) begin
			regA <= readDataA;
			regB <= readDataB;
		end
	end

	controlUnit control (.*);

	aluUnit alu (
		.*,
		.a(aluA),
		.b(aluB),
		.result(aluResult)
	);

	registerFile regs (
		.*,
		.readAddrA(instr.r.rs),
		.readAddrB(instr.r.rt),
		.writeEnable(regWrite)
	);

	pcUnit pcu (
		.*,
		.jumpIndex(instr[25:0])
	);

	busInterface bus (
		.*,
		.storeData(regB)
	);

endmodule

// File: hw/pcUnit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pcUnit (
	input logic clock,
	input logic reset,
	input ctrlPkg::pcSrcT pcSrc,
	input logic [`WORD_WIDTH-1:0] aluResult,
	input logic [`WORD_WIDTH-1:0] aluOut,
	input logic [25:0] jumpIndex,
	input logic pcWrite,
	input logic pcWriteCond,
	input logic branchOnEqual,
	input logic zero,
	input logic epcWrite,
	output logic [`WORD_WIDTH-1:0] pc
);
	import ctrlPkg::*;

	logic [`WORD_WIDTH-1:0] nextPc;
	logic [`WORD_WIDTH-1:0] epc;
	logic pcLoad;

	assign pcLoad = pcWrite || (pcWriteCond && (zero == branchOnEqual));

	always_comb begin
		case (pcSrc)
			pcAluResult: nextPc = aluResult;
			pcAluOut: nextPc = aluOut; // Branch target from decode
			pcJumpTarget: nextPc = {pc[`WORD_WIDTH-1:28], jumpIndex, 2'b00};
			default: nextPc = `EXC_VECTOR;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `RESET_PC;
			epc <= '0;
		end else begin
			if (pcLoad)
				pc <= nextPc;
			if (epcWrite)
				epc <= pc - `PC_STEP; // pc already moved past the faulting word
		end
	end

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module registerFile (
	input logic clock,
	input logic reset,
	input logic [`REG_ADDR_WIDTH-1:0] readAddrA,
	input logic [`REG_ADDR_WIDTH-1:0] readAddrB,
	input logic [`REG_ADDR_WIDTH-1:0] writeAddr,
	input logic [`WORD_WIDTH-1:0] writeData,
	input logic writeEnable,
	output logic [`WORD_WIDTH-1:0] readDataA,
	output logic [`WORD_WIDTH-1:0] readDataB
);
	logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (writeEnable && writeAddr != '0) begin // r0 stays zero
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tbMips \
	-f files.f \
	-o simMips

./obj_dir/simMips

// File: verification/mipsCore_props.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mipsCoreProps (
	input logic clock,
	input logic reset,
	input logic [`WORD_WIDTH-1:0] wbAdr,
	input logic [3:0] wbSel,
	input logic wbWe,
	input logic wbCyc,
	input logic wbStb,
	input logic wbAck
);
	stbWithCyc: assert property (@(posedge clock) disable iff (reset) wbStb |-> wbCyc)
		else $error("wbStb high without wbCyc");

	// Request must hold until the slave acknowledges
	requestHeld: assert property (@(posedge clock) disable iff (reset)
		wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbWe) && $stable(wbSel))
		else $error("bus request changed before acknowledge");

	// Full-word accesses on word boundaries only
	wordAligned: assert property (@(posedge clock) disable iff (reset)
		wbCyc && wbSel == 4'b1111 |-> wbAdr[1:0] == 2'b00)
		else $error("word access to an unaligned address");

	idleAfterReset: assert property (@(posedge clock) reset |=> !wbCyc)
		else $error("wbCyc high right after reset");

endmodule

bind mipsCore mipsCoreProps props0 (
	.clock(clock),
	.reset(reset),
	.wbAdr(wbAdr),
	.wbSel(wbSel),
	.wbWe(wbWe),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbAck(wbAck)
);

// File: verification/tbMips.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tbMips;
	import isaPkg::*;

	localparam int InstrTotal = 49; // Listed words over all programs
	localparam int TestCount = 5;
	localparam int CycleLimit = InstrTotal * 20 + TestCount * 18 + 50;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic [31:0] wbDatR = '0;
	logic wbAck = 1'b0;
	logic [31:0] wbAdr;
	logic [31:0] wbDatW;
	logic [3:0] wbSel;
	logic wbWe;
	logic wbCyc;
	logic wbStb;
	logic halted;

	logic [31:0] mem [256];
	logic [31:0] loadAddr;
	logic pending = 1'b0;
	int waitLeft;

	mipsCore dut0 (.*);

	initial begin
		forever #10 clock = ~clock;
	end

	initial begin
		repeat (CycleLimit) @(posedge clock);
		$display("Timeout: the core did not finish all programs within %0d cycles", CycleLimit);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	// Wishbone slave with 0 to 3 random wait cycles
	always @(posedge clock) begin
		if (reset) begin
			wbAck <= 1'b0;
			pending = 1'b0;
		end else if (wbAck) begin
			wbAck <= 1'b0; // One-cycle acknowledge
		end else if (wbStb) begin
			if (!pending) begin
				pending = 1'b1;
				waitLeft = $urandom % 4;
			end
			if (waitLeft == 0) begin
				pending = 1'b0;
				wbAck <= 1'b1;
				wbDatR <= mem[wbAdr[9:2]];
				if (wbWe) begin
					for (int b = 0; b < 4; b++)
						if (wbSel[b])
							mem[wbAdr[9:2]][b*8 +: 8] = wbDatW[b*8 +: 8];
				end
			end else begin
				waitLeft--;
			end
		end
	end

	function automatic logic [31:0] fillWord(input int idx);
		return {8'hC5, idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h3C};
	endfunction

	function automatic logic [31:0] rInstr(input logic [5:0] funct, input int rd,
			input int rs, input int rt);
		return {6'b000000, rs[4:0], rt[4:0], rd[4:0], 5'b00000, funct};
	endfunction

	function automatic logic [31:0] iInstr(input logic [5:0] op, input int rt,
			input int rs, input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] jInstr(input logic [31:0] target);
		return {6'b000010, target[27:2]};
	endfunction

	task clearMemory;
		for (int i = 0; i < 256; i++)
			mem[i] = fillWord(i);
		loadAddr = `RESET_PC;
	endtask

	task emit(input logic [31:0] word);
		mem[loadAddr[9:2]] = word;
		loadAddr = loadAddr + 32'd4;
	endtask

	task runProgram;
		@(posedge clock);
		reset <= 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		while (!halted)
			@(negedge clock);
	endtask

	task checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s expected %h actual %h", testName, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task expectWord(input string testName, input logic [31:0] addr,
			input logic [31:0] expected);
		checkValue(testName, expected, mem[addr[9:2]]);
	endtask

	task testArithmetic;
		logic [31:0] a;
		logic [31:0] b;
		a = {16'h1765, 16'h0000}; // lui result
		b = fillWord(192);
		clearMemory();
		emit(iInstr(opLui, 1, 0, 16'h1765));
		emit(iInstr(opLw, 2, 0, 16'h0300));
		emit(rInstr(fnAdd, 3, 1, 2));
		emit(rInstr(fnSub, 4, 1, 2));
		emit(rInstr(fnAnd, 5, 1, 2));
		emit(rInstr(fnXor, 6, 1, 2));
		emit(iInstr(opSw, 3, 0, 16'h0200));
		emit(iInstr(opSw, 4, 0, 16'h0204));
		emit(iInstr(opSw, 5, 0, 16'h0208));
		emit(iInstr(opSw, 6, 0, 16'h020C));
		emit(rInstr(fnBreak, 0, 0, 0));
		runProgram();
		expectWord("arithmetic add", 32'h200, a + b);
		expectWord("arithmetic sub", 32'h204, a - b);
		expectWord("arithmetic and", 32'h208, a & b);
		expectWord("arithmetic xor", 32'h20C, a ^ b);
	endtask

	task testByteAccess;
		logic [31:0] src;
		logic [31:0] merged;
		src = fillWord(192);
		merged = fillWord(144);
		merged[15:8] = src[7:0]; // Only lane 1 replaced
		clearMemory();
		emit(iInstr(opLw, 2, 0, 16'h0300));
		emit(iInstr(opSb, 2, 0, 16'h0241));
		emit(iInstr(opSw, 2, 0, 16'h0244));
		emit(iInstr(opLbu, 3, 0, 16'h0247));
		emit(iInstr(opSw, 3, 0, 16'h0248));
		emit(iInstr(opLw, 4, 0, 16'h0244));
		emit(iInstr(opSw, 4, 0, 16'h024C));
		emit(iInstr(opLbu, 5, 0, 16'h0241));
		emit(iInstr(opSw, 5, 0, 16'h0250));
		emit(rInstr(fnBreak, 0, 0, 0));
		runProgram();
		expectWord("byte sb lane", 32'h240, merged);
		expectWord("byte sw word", 32'h244, src);
		expectWord("byte lbu high lane", 32'h248, {24'h000000, src[31:24]});
		expectWord("byte lw round trip", 32'h24C, src);
		expectWord("byte lbu stored lane", 32'h250, {24'h000000, src[7:0]});
	endtask

	task testControlFlow;
		clearMemory();
		emit(iInstr(opLui, 1, 0, 16'h0001));
		emit(iInstr(opLui, 2, 0, 16'h0001));
		emit(iInstr(opLui, 3, 0, 16'h0002));
		emit(iInstr(opBeq, 2, 1, 16'd1)); // Taken
		emit(iInstr(opSw, 1, 0, 16'h0280));
		emit(iInstr(opBeq, 3, 1, 16'd1)); // Not taken
		emit(iInstr(opSw, 1, 0, 16'h0284));
		emit(iInstr(opBne, 3, 1, 16'd1));
		emit(iInstr(opSw, 1, 0, 16'h0288));
		emit(jInstr(32'h2C));
		emit(iInstr(opSw, 1, 0, 16'h028C));
		emit(iInstr(opSw, 3, 0, 16'h0290));
		emit(rInstr(fnBreak, 0, 0, 0));
		runProgram();
		expectWord("flow beq taken", 32'h280, fillWord(160));
		expectWord("flow beq not taken", 32'h284, 32'h00010000);
		expectWord("flow bne taken", 32'h288, fillWord(162));
		expectWord("flow j skip", 32'h28C, fillWord(163));
		expectWord("flow j target", 32'h290, 32'h00020000);
	endtask

	task testOverflow;
		clearMemory();
		emit(iInstr(opLui, 1, 0, 16'h7000));
		emit(iInstr(opLui, 2, 0, 16'h5000));
		emit(iInstr(opLui, 4, 0, 16'h0BAD));
		emit(rInstr(fnAdd, 4, 1, 2)); // Positive sum wraps negative
		emit(iInstr(opSw, 1, 0, 16'h02C0));
		emit(rInstr(fnBreak, 0, 0, 0));
		loadAddr = `EXC_VECTOR;
		emit(iInstr(opLui, 5, 0, 16'hE0C0));
		emit(iInstr(opSw, 5, 0, 16'h02C4));
		emit(iInstr(opSw, 4, 0, 16'h02C8));
		emit(rInstr(fnBreak, 0, 0, 0));
		runProgram();
		expectWord("overflow skipped store", 32'h2C0, fillWord(176));
		expectWord("overflow handler marker", 32'h2C4, 32'hE0C00000);
		expectWord("overflow dest kept", 32'h2C8, 32'h0BAD0000);
	endtask

	task testUndefinedAndHalt;
		clearMemory();
		emit(iInstr(opLui, 1, 0, 16'h00AB));
		emit(32'hFC000000);
		emit(rInstr(6'h01, 1, 0, 0)); // Undefined funct, rd must stay
		emit(iInstr(opSw, 1, 0, 16'h02E0));
		emit(rInstr(fnBreak, 0, 0, 0));
		runProgram();
		expectWord("undefined skipped", 32'h2E0, 32'h00AB0000);
		repeat (50) begin
			@(negedge clock);
			checkValue("halt stays high", 32'd1, {31'd0, halted});
			checkValue("halt bus idle", 32'd0, {31'd0, wbCyc});
		end
	endtask

	initial begin
		void'($urandom(32'he8c1d975));
		testArithmetic();
		testByteAccess();
		testControlFlow();
		testOverflow();
		testUndefinedAndHalt();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
